//--- verilog.f
+incdir+include
rtl/rv_pkg.sv
rtl/rv_pipe_if.sv
rtl/rv_fetch.sv
rtl/rv_regfile.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_result.sv
rtl/rv_core_top.sv
tb/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - files:
      - rtl/rv_pkg.sv
      - rtl/rv_pipe_if.sv
      - rtl/rv_fetch.sv
      - rtl/rv_regfile.sv
      - rtl/rv_decode.sv
      - rtl/rv_execute.sv
      - rtl/rv_result.sv
      - rtl/rv_core_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_rv_core.sv

//--- include/rv_tb_prog.svh
// RV32I instruction encoders and reference models
// used by the core testbench to build programs and predict IO writes
`ifndef RV_TB_PROG_SVH
`define RV_TB_PROG_SVH

function automatic logic [6:0] op7(input rv_pkg::opcode_e op);
   return {op, 2'b11};
endfunction

function automatic rv_pkg::word_t enc_r(input logic [6:0] f7, input rv_pkg::reg_id_t rs2,
                                        input rv_pkg::reg_id_t rs1, input logic [2:0] f3,
                                        input rv_pkg::reg_id_t rd);
   return {f7, rs2, rs1, f3, rd, op7(rv_pkg::OP_REG)};
endfunction

function automatic rv_pkg::word_t enc_i(input rv_pkg::opcode_e op, input logic [11:0] imm,
                                        input rv_pkg::reg_id_t rs1, input logic [2:0] f3,
                                        input rv_pkg::reg_id_t rd);
   return {imm, rs1, f3, rd, op7(op)};
endfunction

function automatic rv_pkg::word_t enc_s(input logic [11:0] imm, input rv_pkg::reg_id_t rs2,
                                        input rv_pkg::reg_id_t rs1, input logic [2:0] f3);
   return {imm[11:5], rs2, rs1, f3, imm[4:0], op7(rv_pkg::OP_STORE)};
endfunction

// imm is a byte offset, bit 0 dropped
function automatic rv_pkg::word_t enc_b(input logic [12:0] imm, input rv_pkg::reg_id_t rs2,
                                        input rv_pkg::reg_id_t rs1, input logic [2:0] f3);
   return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op7(rv_pkg::OP_BRANCH)};
endfunction

function automatic rv_pkg::word_t enc_u(input rv_pkg::opcode_e op, input logic [19:0] imm,
                                        input rv_pkg::reg_id_t rd);
   return {imm, rd, op7(op)};
endfunction

function automatic rv_pkg::word_t enc_j(input logic [20:0] imm, input rv_pkg::reg_id_t rd);
   return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op7(rv_pkg::OP_JAL)};
endfunction

function automatic rv_pkg::word_t enc_ebreak();
   return {12'd1, 5'd0, 3'd0, 5'd0, op7(rv_pkg::OP_SYSTEM)};
endfunction

function automatic rv_pkg::word_t ref_alu(input logic [2:0] f3, input logic sub,
                                          input logic arith, input rv_pkg::word_t a,
                                          input rv_pkg::word_t b);
   case (f3)
      3'b000:  return sub ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'd0, $signed(a) < $signed(b)};
      3'b011:  return {31'd0, a < b};
      3'b100:  return a ^ b;
      3'b101:  return arith ? rv_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
   endcase
endfunction

// value a load with funct3 f3 returns from RAM word w at byte offset off
function automatic rv_pkg::word_t ref_load(input rv_pkg::word_t w, input logic [1:0] off,
                                           input logic [2:0] f3);
   logic [7:0]  b;
   logic [15:0] h;
   b = w[8*off +: 8];
   h = w[16*off[1] +: 16];
   case (f3)
      3'b000:  return {{24{b[7]}}, b};
      3'b001:  return {{16{h[15]}}, h};
      3'b100:  return {24'd0, b};
      3'b101:  return {16'd0, h};
      default: return w;
   endcase
endfunction

`endif

//--- tb/tb_rv_core.sv
`timescale 1ns/1ps
// testbench for the sequential RV32I core
// builds one program of six tests, loads it during reset and checks every IO write
module tb_rv_core;
   `include "rv_tb_prog.svh"

   localparam int            io_credits = 2;
   localparam rv_pkg::word_t io_base    = 32'h0040_0000;

   logic          clk;
   logic          resetn;
   logic          prog_we;
   rv_pkg::word_t prog_addr;
   rv_pkg::word_t prog_data;
   logic          io_credit;
   logic          io_valid;
   rv_pkg::word_t io_addr;
   rv_pkg::word_t io_data;
   logic          halted;

   integer        seed;
   rv_pkg::word_t prog [$];
   rv_pkg::word_t exp_addr [$];
   rv_pkg::word_t exp_data [$];
   int            pending [$];   // cycles at which credits go back
   int            remaining [1:6];
   int            test_errs [1:6];
   string         names [1:6];
   int            cur_test;
   int            errors;
   int            checks;
   int            passed;
   int            failed;
   int            cycle;
   int            limit;
   int            delay_total;
   int            outstanding;   // credits spent and not yet returned
   int            peak;

   rv_core_top u_rv_core_top (
      .clk, .resetn, .prog_we, .prog_addr, .prog_data, .io_credit,
      .io_valid, .io_addr, .io_data, .halted
   );

   always #10 clk = ~clk;

   function automatic int credit_delay(input int test);
      return (test == 5) ? 60 : 2;   // test 5 holds its credits back
   endfunction

   function automatic logic ref_branch(input logic [2:0] f3, input rv_pkg::word_t a,
                                       input rv_pkg::word_t b);
      case (f3)
         3'b000:  return a == b;
         3'b001:  return a != b;
         3'b100:  return $signed(a) < $signed(b);
         3'b101:  return $signed(a) >= $signed(b);
         3'b110:  return a < b;
         default: return a >= b;
      endcase
   endfunction

   function automatic rv_pkg::word_t sext12(input logic [11:0] v);
      return {{20{v[11]}}, v};
   endfunction

   task automatic emit(input rv_pkg::word_t w);
      prog.push_back(w);
   endtask

   task automatic load_const(input rv_pkg::reg_id_t rd, input rv_pkg::word_t v);
      rv_pkg::word_t up;
      up = v + 32'h800;   // addi sign extends the low part
      emit(enc_u(rv_pkg::OP_LUI, up[31:12], rd));
      emit(enc_i(rv_pkg::OP_IMM, v[11:0], rd, 3'b000, rd));
   endtask

   // x31 holds the IO page, the offset tags the test
   task automatic store_to_io(input int test, input rv_pkg::reg_id_t rs);
      emit(enc_s(12'(test * 16), rs, 5'd31, 3'b010));
   endtask

   task automatic expect_io(input int test, input rv_pkg::word_t value);
      exp_addr.push_back(io_base + rv_pkg::word_t'(test * 16));
      exp_data.push_back(value);
      remaining[test]++;
      delay_total += credit_delay(test);
   endtask

   task automatic build_program();
      rv_pkg::word_t a;
      rv_pkg::word_t b;
      rv_pkg::word_t x;
      rv_pkg::word_t y;
      rv_pkg::word_t w;
      rv_pkg::word_t t;
      logic [11:0]   imm;
      logic [19:0]   up;
      logic [2:0]    f3;
      logic          alt;
      int            j;
      int            off;
      int            sb_off;
      int            sh_off;
      emit(enc_u(rv_pkg::OP_LUI, 20'h00400, 5'd31));
      // register ops, sub and sra come as the last two of each round
      for (int k = 0; k < 20; k++) begin
         j   = k % 10;
         f3  = (j < 8) ? 3'(j) : ((j == 8) ? 3'b000 : 3'b101);
         alt = (j >= 8);
         a   = $random(seed);
         b   = $random(seed);
         load_const(5'd1, a);
         load_const(5'd2, b);
         emit(enc_r({1'b0, alt, 5'd0}, 5'd2, 5'd1, f3, 5'd3));
         store_to_io(1, 5'd3);
         expect_io(1, ref_alu(f3, alt, alt, a, b));
      end
      for (int k = 0; k < 9; k++) begin
         f3  = (k < 8) ? 3'(k) : 3'b101;
         alt = (k == 8);   // srai
         a   = $random(seed);
         imm = 12'($random(seed));
         if (f3 == 3'b001 || f3 == 3'b101)
            imm = {1'b0, alt, 5'd0, imm[4:0]};
         load_const(5'd1, a);
         emit(enc_i(rv_pkg::OP_IMM, imm, 5'd1, f3, 5'd3));
         store_to_io(2, 5'd3);
         expect_io(2, ref_alu(f3, 1'b0, alt, a, sext12(imm)));
      end
      up = 20'($random(seed));
      emit(enc_u(rv_pkg::OP_LUI, up, 5'd3));
      store_to_io(2, 5'd3);
      expect_io(2, {up, 12'd0});
      up = 20'($random(seed));
      t  = rv_pkg::word_t'(prog.size() * 4);
      emit(enc_u(rv_pkg::OP_AUIPC, up, 5'd3));
      store_to_io(2, 5'd3);
      expect_io(2, t + {up, 12'd0});
      emit(enc_i(rv_pkg::OP_IMM, 12'd2, 5'd0, 3'b000, 5'd5));   // not-taken marker
      emit(enc_i(rv_pkg::OP_IMM, 12'd1, 5'd0, 3'b000, 5'd6));   // taken marker
      for (int k = 0; k < 18; k++) begin
         f3 = ((k / 3) < 2) ? 3'(k / 3) : 3'(k / 3 + 2);
         if (k % 3 == 0) begin
            a = $random(seed);
            b = $random(seed);
         end
         x = (k % 3 == 1) ? b : a;   // operand order (a,b), (b,a), (a,a)
         y = (k % 3 == 0) ? b : a;
         load_const(5'd1, x);
         load_const(5'd2, y);
         emit(enc_b(13'd12, 5'd2, 5'd1, f3));
         store_to_io(3, 5'd5);
         emit(enc_j(21'd8, 5'd0));
         store_to_io(3, 5'd6);
         expect_io(3, ref_branch(f3, x, y) ? 32'd1 : 32'd2);
      end
      t = rv_pkg::word_t'(prog.size() * 4);
      emit(enc_j(21'd8, 5'd7));
      store_to_io(3, 5'd6);   // jumped over
      store_to_io(3, 5'd7);
      expect_io(3, t + 32'd4);
      t = rv_pkg::word_t'(prog.size() * 4 + 16);   // jalr landing address
      load_const(5'd8, t);
      emit(enc_i(rv_pkg::OP_JALR, 12'd1, 5'd8, 3'b000, 5'd9));   // odd target, bit 0 dropped
      store_to_io(3, 5'd6);
      store_to_io(3, 5'd9);
      expect_io(3, t - 32'd4);
      emit(enc_i(rv_pkg::OP_IMM, 12'h100, 5'd0, 3'b000, 5'd10));   // RAM base
      for (int r = 0; r < 2; r++) begin
         sb_off = (r != 0) ? 3 : 1;
         sh_off = (r != 0) ? 0 : 2;
         w = $random(seed);
         a = $random(seed);
         b = $random(seed);
         load_const(5'd1, w);
         load_const(5'd2, a);
         load_const(5'd4, b);
         emit(enc_s(12'(4 * r), 5'd1, 5'd10, 3'b010));
         emit(enc_s(12'(4 * r + sb_off), 5'd2, 5'd10, 3'b000));
         emit(enc_s(12'(4 * r + sh_off), 5'd4, 5'd10, 3'b001));
         w[8*sb_off +: 8]  = a[7:0];
         w[8*sh_off +: 16] = b[15:0];
         for (int i = 0; i < 20; i++) begin
            off = i / 5;
            f3  = ((i % 5) < 3) ? 3'(i % 5) : 3'(i % 5 + 1);   // lb lh lw lbu lhu
            if (!((f3[1:0] == 2'b01 && off[0]) || (f3[1:0] == 2'b10 && off != 0))) begin
               emit(enc_i(rv_pkg::OP_LOAD, 12'(4 * r + off), 5'd10, f3, 5'd3));
               store_to_io(4, 5'd3);
               expect_io(4, ref_load(w, 2'(off), f3));
            end
         end
      end
      // six stores in a row, faster than the credits come back
      for (int k = 0; k < 6; k++) begin
         imm = 12'($random(seed));
         emit(enc_i(rv_pkg::OP_IMM, imm, 5'd0, 3'b000, rv_pkg::reg_id_t'(11 + k)));
         expect_io(5, sext12(imm));
      end
      for (int k = 0; k < 6; k++)
         store_to_io(5, rv_pkg::reg_id_t'(11 + k));
      emit(enc_ebreak());
      store_to_io(6, 5'd5);   // must never leave the core
      store_to_io(6, 5'd6);
   endtask

   task automatic check_io(input string name, input rv_pkg::word_t expected,
                           input rv_pkg::word_t actual);
      checks++;
      if (actual !== expected) begin
         $display("error %s: expected %h got %h (test %0d)", name, expected, actual, cur_test);
         errors++;
         test_errs[cur_test]++;
      end
   endtask

   task automatic check_halt(input logic expected, input logic actual);
      checks++;
      if (actual !== expected) begin
         $display("error halted: expected %h got %h", expected, actual);
         errors++;
         test_errs[cur_test]++;
      end
   endtask

   task automatic report_failure(input string msg);
      $display("%s (test %0d)", msg, cur_test);
      errors++;
      test_errs[cur_test]++;
   endtask

   task automatic report_test(input int t);
      if (test_errs[t] == 0)
         passed++;
      else
         failed++;
      $display("test %0d %s: %s, %0d errors", t, names[t],
               (test_errs[t] == 0) ? "passed" : "failed", test_errs[t]);
   endtask

   task automatic take_io();
      rv_pkg::word_t ea;
      rv_pkg::word_t ed;
      int            t;
      t = 6;
      if (exp_addr.size() == 0) begin
         cur_test = t;
         report_failure($sformatf("IO write to %h arrived when none was expected", io_addr));
      end else begin
         ea       = exp_addr.pop_front();
         ed       = exp_data.pop_front();
         t        = (ea - io_base) / 16;
         cur_test = t;
         check_io("io_addr", ea, io_addr);
         check_io("io_data", ed, io_data);
      end
      if (outstanding >= io_credits)
         report_failure("IO write issued with no credit left");
      pending.push_back(cycle + credit_delay(t));
      outstanding++;
      if (t == 5 && outstanding > peak)
         peak = outstanding;
      if (t != 6) begin
         remaining[t]--;
         if (remaining[t] == 0) begin
            if (t == 5 && peak < io_credits)
               report_failure("credits were never used up while returns were held back");
            report_test(t);
         end
      end
   endtask

   // IO port and credit accounting, sampled mid-cycle
   always @(negedge clk) begin
      if (resetn === 1'b1) begin
         cycle++;
         if (cycle > limit) begin
            $display("timeout after %0d cycles, the core never halted", cycle);
            $display("Test FAILED");
            $finish;
         end else begin
            if (io_valid === 1'b1)
               take_io();
            else if (io_valid !== 1'b0)
               report_failure("io_valid is unknown");
            if (io_credit)
               outstanding--;
         end
      end
   end

   // one credit back per cycle once its delay is up
   always @(posedge clk) begin
      #2;
      io_credit = 1'b0;
      if (resetn && pending.size() > 0 && pending[0] <= cycle) begin
         pending.delete(0);
         io_credit = 1'b1;
      end
   end

   initial begin
      clk       = 1'b0;
      resetn    = 1'b0;
      prog_we   = 1'b0;
      prog_addr = '0;
      prog_data = '0;
      io_credit = 1'b0;
      seed      = 32'h4684;
      cur_test  = 6;
      limit     = 1000;
      names[1]  = "register ALU";
      names[2]  = "immediate ALU, lui, auipc";
      names[3]  = "branches and jumps";
      names[4]  = "loads and stores";
      names[5]  = "credit back-pressure";
      names[6]  = "ebreak";
      build_program();
      limit = prog.size() * 5 + delay_total + 200;
      // program goes in while the core sits in reset
      for (int i = 0; i < prog.size(); i++) begin
         @(posedge clk);
         #2;
         prog_we   = 1'b1;
         prog_addr = rv_pkg::word_t'(i * 4);
         prog_data = prog[i];
      end
      @(posedge clk);
      #2;
      prog_we = 1'b0;
      repeat (8) @(posedge clk);
      #2;
      resetn = 1'b1;
      @(negedge clk);
      check_halt(1'b0, halted);
      while (halted !== 1'b1)
         @(negedge clk);
      repeat (20) @(negedge clk);   // window for stray writes after ebreak
      cur_test = 6;
      check_halt(1'b1, halted);
      if (exp_addr.size() != 0)
         report_failure($sformatf("%0d expected IO writes never appeared", exp_addr.size()));
      report_test(6);
      $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
               passed, failed, checks, errors);
      if (errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

//--- rtl/rv_core_top.sv
`timescale 1ns/1ps
// sequential five-step RV32I core
// program load port in, credited IO write port out
module rv_core_top (
   input  logic          clk,
   input  logic          resetn,
   input  logic          prog_we,
   input  rv_pkg::word_t prog_addr,
   input  rv_pkg::word_t prog_data,
   input  logic          io_credit,
   output logic          io_valid,
   output rv_pkg::word_t io_addr,
   output rv_pkg::word_t io_data,
   output logic          halted
);
   localparam int PROG_WORDS = 1024;
   localparam int DATA_WORDS = 1024;
   localparam int IO_CREDITS = 2;

   rv_pkg::word_t   instr;
   rv_pkg::word_t   pc;
   rv_pkg::reg_id_t rs1;
   rv_pkg::reg_id_t rs2;
   rv_pkg::word_t   rs1_val;
   rv_pkg::word_t   rs2_val;
   rv_pkg::reg_id_t wb_rd;
   rv_pkg::word_t   wb_data;
   logic            wb_we;
   logic            is_ebreak;
   logic            mem_stall;
   logic            dec_en;
   logic            exe_en;
   logic            mem_en;
   logic            wb_en;

   de_if u_de ();
   er_if u_er ();

   rv_fetch #(.PROG_WORDS(PROG_WORDS)) u_fetch (
      .clk, .resetn, .prog_we, .prog_addr, .prog_data, .is_ebreak, .mem_stall,
      .take(u_er.take), .target(u_er.addr),
      .instr, .pc, .dec_en, .exe_en, .mem_en, .wb_en, .halted
   );

   rv_regfile u_regfile (
      .clk, .rs1, .rs2, .wb_we, .wb_rd, .wb_data, .rs1_val, .rs2_val
   );

   rv_decode u_decode (
      .clk, .dec_en, .instr, .pc, .rs1_val, .rs2_val, .rs1, .rs2, .is_ebreak,
      .de(u_de.producer)
   );

   rv_execute u_execute (.clk, .exe_en, .de(u_de.consumer), .er(u_er.producer));

   rv_result #(.DATA_WORDS(DATA_WORDS), .IO_CREDITS(IO_CREDITS)) u_result (
      .clk, .resetn, .mem_en, .wb_en, .er(u_er.consumer), .io_credit,
      .mem_stall, .io_valid, .io_addr, .io_data, .wb_we, .wb_rd, .wb_data
   );

endmodule

//--- rtl/rv_result.sv
`timescale 1ns/1ps
// memory and writeback steps
// data RAM with byte lanes, credited IO write port, load extension and register write
module rv_result #(
   parameter int DATA_WORDS = 1024,
   parameter int IO_CREDITS = 2
) (
   input  logic            clk,
   input  logic            resetn,
   input  logic            mem_en,
   input  logic            wb_en,
   er_if.consumer          er,
   input  logic            io_credit,
   output logic            mem_stall,
   output logic            io_valid,
   output rv_pkg::word_t   io_addr,
   output rv_pkg::word_t   io_data,
   output logic            wb_we,
   output rv_pkg::reg_id_t wb_rd,
   output rv_pkg::word_t   wb_data
);
   localparam int DAW = $clog2(DATA_WORDS);
   localparam int CW  = $clog2(IO_CREDITS + 1);

   rv_pkg::word_t  data_ram [DATA_WORDS];
   rv_pkg::word_t  store_data;
   rv_pkg::word_t  mem_rdata;
   rv_pkg::word_t  load_data;
   logic [3:0]     wmask;
   logic [DAW-1:0] word_addr;
   logic [CW-1:0]  credits;
   logic           is_byte;
   logic           is_half;
   logic           io_store;
   logic [15:0]    load_half;
   logic [7:0]     load_byte;
   logic           load_sign;

   assign is_byte   = (er.ctrl.funct3[1:0] == 2'b00);
   assign is_half   = (er.ctrl.funct3[1:0] == 2'b01);
   assign word_addr = er.addr[DAW+1:2];
   assign io_store  = er.ctrl.is_store && er.addr[rv_pkg::IO_PAGE_BIT];

   // replicate the low bytes so every lane sees its data
   assign store_data[7:0]   = er.rs2_val[7:0];
   assign store_data[15:8]  = er.addr[0] ? er.rs2_val[7:0] : er.rs2_val[15:8];
   assign store_data[23:16] = er.addr[1] ? er.rs2_val[7:0] : er.rs2_val[23:16];
   assign store_data[31:24] = er.addr[0] ? er.rs2_val[7:0] :
                              er.addr[1] ? er.rs2_val[15:8] : er.rs2_val[31:24];

   assign wmask = is_byte ? (4'b0001 << er.addr[1:0]) :
                  is_half ? (er.addr[1] ? 4'b1100 : 4'b0011) :
                            4'b1111;

   always_ff @(posedge clk) begin
      if (mem_en) begin
         mem_rdata <= data_ram[word_addr];
         for (int b = 0; b < 4; b++) begin
            if (er.ctrl.is_store && !io_store && wmask[b])
               data_ram[word_addr][8*b +: 8] <= store_data[8*b +: 8];
         end
      end
   end

   // IO stores wait here until a credit is in hand
   assign mem_stall = mem_en && io_store && (credits == '0);
   assign io_valid  = mem_en && io_store && (credits != '0);
   assign io_addr   = er.addr;
   assign io_data   = er.rs2_val;

   always_ff @(posedge clk) begin
      if (!resetn)
         credits <= CW'(IO_CREDITS);
      else
         credits <= credits - CW'(io_valid) + CW'(io_credit);
   end

   assign load_half = er.addr[1] ? mem_rdata[31:16] : mem_rdata[15:0];
   assign load_byte = er.addr[0] ? load_half[15:8] : load_half[7:0];
   assign load_sign = !er.ctrl.funct3[2] && (is_byte ? load_byte[7] : load_half[15]);
   assign load_data = is_byte ? {{24{load_sign}}, load_byte} :
                      is_half ? {{16{load_sign}}, load_half} :
                                mem_rdata;

   assign wb_we   = wb_en && er.ctrl.wb_en;
   assign wb_rd   = er.ctrl.rd;
   assign wb_data = er.ctrl.is_load ? load_data : er.result;

   // environment must never hand back more than it was given
   a_credit_max: assert property (
      @(posedge clk) disable iff (!resetn) credits <= CW'(IO_CREDITS));

endmodule

//--- rtl/rv_execute.sv
`timescale 1ns/1ps
// execute step
// ALU, single shifter, branch test and target or load/store address
module rv_execute (
   input  logic   clk,
   input  logic   exe_en,
   de_if.consumer de,
   er_if.producer er
);
   rv_pkg::word_t alu_in1;
   rv_pkg::word_t alu_in2;
   rv_pkg::word_t alu_plus;
   logic [32:0]   alu_minus;
   logic          lt;
   logic          ltu;
   logic          eq;
   rv_pkg::word_t shift_in;
   logic [32:0]   shift_full;
   rv_pkg::word_t alu_out;
   rv_pkg::word_t pc_plus_imm;
   rv_pkg::word_t pc_plus4;
   logic          take;

   function automatic rv_pkg::word_t flip(input rv_pkg::word_t x);
      rv_pkg::word_t y;
      for (int i = 0; i < rv_pkg::xlen; i++) begin
         y[i] = x[rv_pkg::xlen-1-i];
      end
      return y;
   endfunction

   assign alu_in1 = de.rs1_val;
   assign alu_in2 = (de.ctrl.is_alu_reg || de.ctrl.is_branch) ? de.rs2_val : de.imm;

   assign alu_plus  = alu_in1 + alu_in2;
   // one 33-bit subtract gives sub and all compares
   assign alu_minus = {1'b1, ~alu_in2} + {1'b0, alu_in1} + 33'd1;
   assign ltu       = alu_minus[32];
   assign lt        = (alu_in1[31] ^ alu_in2[31]) ? alu_in1[31] : alu_minus[32];
   assign eq        = (alu_minus[31:0] == '0);

   // left shifts go through the right shifter bit reversed
   assign shift_in   = (de.ctrl.funct3 == 3'b001) ? flip(alu_in1) : alu_in1;
   assign shift_full = $signed({de.ctrl.arith & alu_in1[31], shift_in}) >>> alu_in2[4:0];

   always_comb begin
      case (rv_pkg::alu_fn_e'(de.ctrl.funct3))
         rv_pkg::ALU_ADD:  alu_out = de.ctrl.sub ? alu_minus[31:0] : alu_plus;
         rv_pkg::ALU_SLL:  alu_out = flip(shift_full[31:0]);
         rv_pkg::ALU_SLT:  alu_out = {31'd0, lt};
         rv_pkg::ALU_SLTU: alu_out = {31'd0, ltu};
         rv_pkg::ALU_XOR:  alu_out = alu_in1 ^ alu_in2;
         rv_pkg::ALU_SHR:  alu_out = shift_full[31:0];
         rv_pkg::ALU_OR:   alu_out = alu_in1 | alu_in2;
         default:          alu_out = alu_in1 & alu_in2;
      endcase
   end

   always_comb begin
      take = de.ctrl.is_jal || de.ctrl.is_jalr;
      if (de.ctrl.is_branch) begin
         case (rv_pkg::branch_fn_e'(de.ctrl.funct3))
            rv_pkg::BR_EQ:  take = eq;
            rv_pkg::BR_NE:  take = !eq;
            rv_pkg::BR_LT:  take = lt;
            rv_pkg::BR_GE:  take = !lt;
            rv_pkg::BR_LTU: take = ltu;
            rv_pkg::BR_GEU: take = !ltu;
            default:        take = 1'b0;   // reserved funct3 never branches
         endcase
      end
   end

   assign pc_plus_imm = de.pc + de.imm;
   assign pc_plus4    = de.pc + 32'd4;

   always_ff @(posedge clk) begin
      if (exe_en) begin
         er.result  <= (de.ctrl.is_jal || de.ctrl.is_jalr) ? pc_plus4    :
                       de.ctrl.is_lui                      ? de.imm      :
                       de.ctrl.is_auipc                    ? pc_plus_imm :
                                                             alu_out;
         er.addr    <= (de.ctrl.is_branch || de.ctrl.is_jal) ? pc_plus_imm            :
                       de.ctrl.is_jalr                       ? {alu_plus[31:1], 1'b0} :
                                                               alu_plus;
         er.rs2_val <= de.rs2_val;
         er.take    <= take;
         er.ctrl    <= de.ctrl;
      end
   end

endmodule

//--- rtl/rv_decode.sv
`timescale 1ns/1ps
// instruction decode
// classifies the opcode, builds the immediate and registers operands into de_if
module rv_decode (
   input  logic            clk,
   input  logic            dec_en,
   input  rv_pkg::word_t   instr,
   input  rv_pkg::word_t   pc,
   input  rv_pkg::word_t   rs1_val,
   input  rv_pkg::word_t   rs2_val,
   output rv_pkg::reg_id_t rs1,
   output rv_pkg::reg_id_t rs2,
   output logic            is_ebreak,
   de_if.producer          de
);
   rv_pkg::opcode_e opcode;
   rv_pkg::ctrl_t   ctrl;
   rv_pkg::word_t   imm_u;
   rv_pkg::word_t   imm_i;
   rv_pkg::word_t   imm_s;
   rv_pkg::word_t   imm_b;
   rv_pkg::word_t   imm_j;
   rv_pkg::word_t   imm;

   assign opcode = rv_pkg::opcode_e'(instr[6:2]);
   assign rs1    = instr[19:15];
   assign rs2    = instr[24:20];

   assign is_ebreak = (opcode == rv_pkg::OP_SYSTEM) && (instr[14:12] == 3'b000) && instr[20];

   assign imm_u = {instr[31:12], 12'd0};
   assign imm_i = {{21{instr[31]}}, instr[30:20]};
   assign imm_s = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

   always_comb begin
      case (opcode)
         rv_pkg::OP_LUI, rv_pkg::OP_AUIPC:               imm = imm_u;
         rv_pkg::OP_IMM, rv_pkg::OP_JALR, rv_pkg::OP_LOAD: imm = imm_i;
         rv_pkg::OP_STORE:                               imm = imm_s;
         rv_pkg::OP_BRANCH:                              imm = imm_b;
         default:                                        imm = imm_j;
      endcase
   end

   always_comb begin
      ctrl.is_alu_reg = (opcode == rv_pkg::OP_REG);
      ctrl.is_alu_imm = (opcode == rv_pkg::OP_IMM);
      ctrl.is_branch  = (opcode == rv_pkg::OP_BRANCH);
      ctrl.is_jal     = (opcode == rv_pkg::OP_JAL);
      ctrl.is_jalr    = (opcode == rv_pkg::OP_JALR);
      ctrl.is_auipc   = (opcode == rv_pkg::OP_AUIPC);
      ctrl.is_lui     = (opcode == rv_pkg::OP_LUI);
      ctrl.is_load    = (opcode == rv_pkg::OP_LOAD);
      ctrl.is_store   = (opcode == rv_pkg::OP_STORE);
      ctrl.funct3     = instr[14:12];
      ctrl.sub        = instr[30] & ctrl.is_alu_reg;
      ctrl.arith      = instr[30];
      ctrl.rd         = instr[11:7];
      // branches, stores, system and rd zero leave the register file alone
      ctrl.wb_en      = (ctrl.rd != 5'd0) &&
                        (ctrl.is_alu_reg || ctrl.is_alu_imm || ctrl.is_jal || ctrl.is_jalr ||
                         ctrl.is_auipc || ctrl.is_lui || ctrl.is_load);
   end

   always_ff @(posedge clk) begin
      if (dec_en) begin
         de.rs1_val <= rs1_val;
         de.rs2_val <= rs2_val;
         de.imm     <= imm;
         de.pc      <= pc;
         de.ctrl    <= ctrl;
      end
   end

   a_one_class: assert property (@(posedge clk) dec_en |=> $onehot0(de.ctrl[19:11]));

endmodule

//--- rtl/rv_regfile.sv
`timescale 1ns/1ps
// integer register file, two read ports and one write port
module rv_regfile (
   input  logic            clk,
   input  rv_pkg::reg_id_t rs1,
   input  rv_pkg::reg_id_t rs2,
   input  logic            wb_we,
   input  rv_pkg::reg_id_t wb_rd,
   input  rv_pkg::word_t   wb_data,
   output rv_pkg::word_t   rs1_val,
   output rv_pkg::word_t   rs2_val
);
   rv_pkg::word_t regs [32];

   // x0 reads as zero whatever is stored there
   assign rs1_val = (rs1 == 5'd0) ? '0 : regs[rs1];
   assign rs2_val = (rs2 == 5'd0) ? '0 : regs[rs2];

   always_ff @(posedge clk) begin
      if (wb_we)
         regs[wb_rd] <= wb_data;
   end

endmodule

//--- rtl/rv_fetch.sv
`timescale 1ns/1ps
// instruction fetch and step sequencer
// program memory, pc and the one-hot ring of the five steps
module rv_fetch #(
   parameter int PROG_WORDS = 1024
) (
   input  logic          clk,
   input  logic          resetn,
   input  logic          prog_we,
   input  rv_pkg::word_t prog_addr,   // byte address
   input  rv_pkg::word_t prog_data,
   input  logic          is_ebreak,
   input  logic          mem_stall,
   input  logic          take,
   input  rv_pkg::word_t target,
   output rv_pkg::word_t instr,
   output rv_pkg::word_t pc,
   output logic          dec_en,
   output logic          exe_en,
   output logic          mem_en,
   output logic          wb_en,
   output logic          halted
);
   localparam int AW = $clog2(PROG_WORDS);

   rv_pkg::word_t prog_mem [PROG_WORDS];
   rv_pkg::word_t fetch_pc;
   logic [4:0]    step;   // fetch, decode, execute, memory, writeback

   assign dec_en = step[1];
   assign exe_en = step[2];
   assign mem_en = step[3];
   assign wb_en  = step[4];

   always_ff @(posedge clk) begin
      if (!resetn) begin
         step   <= 5'b00001;
         halted <= 1'b0;
      end else begin
         if (!halted && !(mem_en && mem_stall))
            step <= {step[3:0], step[4]};   // ring freezes at execute after ebreak
         if (dec_en && is_ebreak)
            halted <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!resetn)
         fetch_pc <= '0;
      else if (step[0])
         fetch_pc <= fetch_pc + 32'd4;
      else if (mem_en && take)
         fetch_pc <= target;   // redirect wins in the memory step
   end

   // program load only while the core is held in reset
   always_ff @(posedge clk) begin
      if (prog_we && !resetn)
         prog_mem[prog_addr[AW+1:2]] <= prog_data;
      if (step[0]) begin
         instr <= prog_mem[fetch_pc[AW+1:2]];
         pc    <= fetch_pc;
      end
   end

   a_ring_onehot: assert property (@(posedge clk) disable iff (!resetn) $onehot(step));

endmodule

//--- rtl/rv_pipe_if.sv
`timescale 1ns/1ps
// step-to-step buses of the sequential core
// de_if runs decode to execute, er_if runs execute to memory and writeback

interface de_if;
   rv_pkg::word_t rs1_val;
   rv_pkg::word_t rs2_val;
   rv_pkg::word_t imm;
   rv_pkg::word_t pc;
   rv_pkg::ctrl_t ctrl;

   modport producer (output rs1_val, rs2_val, imm, pc, ctrl);
   modport consumer (input rs1_val, rs2_val, imm, pc, ctrl);
endinterface

interface er_if;
   rv_pkg::word_t result;    // execute result for writeback
   rv_pkg::word_t addr;      // branch target or load/store address
   rv_pkg::word_t rs2_val;   // store data
   logic          take;
   rv_pkg::ctrl_t ctrl;

   modport producer (output result, addr, rs2_val, take, ctrl);
   modport consumer (input result, addr, rs2_val, take, ctrl);
endinterface

//--- rtl/rv_pkg.sv
// RV32I core shared definitions
// widths, major opcodes, function codes and the decoded control word
package rv_pkg;

   localparam int xlen        = 32;
   localparam int IO_PAGE_BIT = 22;   // address bit selecting the IO page

   typedef logic [xlen-1:0] word_t;
   typedef logic [4:0]      reg_id_t;

   // instruction bits 6 to 2
   typedef enum logic [4:0] {
      OP_LOAD   = 5'b00000,
      OP_IMM    = 5'b00100,
      OP_AUIPC  = 5'b00101,
      OP_STORE  = 5'b01000,
      OP_REG    = 5'b01100,
      OP_LUI    = 5'b01101,
      OP_BRANCH = 5'b11000,
      OP_JALR   = 5'b11001,
      OP_JAL    = 5'b11011,
      OP_SYSTEM = 5'b11100
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD  = 3'b000,   // add or sub
      ALU_SLL  = 3'b001,
      ALU_SLT  = 3'b010,
      ALU_SLTU = 3'b011,
      ALU_XOR  = 3'b100,
      ALU_SHR  = 3'b101,   // srl or sra
      ALU_OR   = 3'b110,
      ALU_AND  = 3'b111
   } alu_fn_e;

   typedef enum logic [2:0] {
      BR_EQ  = 3'b000,
      BR_NE  = 3'b001,
      BR_LT  = 3'b100,
      BR_GE  = 3'b101,
      BR_LTU = 3'b110,
      BR_GEU = 3'b111
   } branch_fn_e;

   typedef struct packed {
      logic       is_alu_reg;
      logic       is_alu_imm;
      logic       is_branch;
      logic       is_jal;
      logic       is_jalr;
      logic       is_auipc;
      logic       is_lui;
      logic       is_load;
      logic       is_store;
      logic [2:0] funct3;
      logic       sub;     // funct7 bit 5 on register ops
      logic       arith;   // instr bit 30, sra and srai
      reg_id_t    rd;
      logic       wb_en;
   } ctrl_t;

endpackage
